// File: verilog.f
+incdir+logic
logic/rx_pkg.sv
logic/rx_cfg_if.sv
logic/rx_settings_regs.sv
logic/rx_dc_offset.sv
logic/rx_iq_correct.sv
logic/rx_frontend.sv
bench/rx_clock_gen.sv
bench/rx_frontend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the receive front-end testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f \
   --top-module rx_frontend_tb \
   -o rx_sim

./obj_dir/rx_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log
then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// File: bench/rx_cases.txt
# t <test> <name> | w <addr> <data> | s <adc_a> <adc_b> <run> <exp_i> <exp_q>
# All values hex except the test number
t 1 reset_defaults
s 1234 fedc 0 123400 fedc00
s 7fff 8000 0 7fff00 800000
s 0000 0001 0 000000 000100
t 2 channel_swap
w 00 00000001
s 0102 0304 0 030400 010200
s abcd 0005 0 000500 abcd00
w 00 00000000
s 0102 0304 0 010200 030400
t 3 fixed_dc
w 03 80080000
w 04 b8000000
s 0100 0100 0 00f000 910000
s 0000 8000 0 fff000 800000
t 4 dc_tracking
w 03 00000000
w 04 00000000
s 0000 0000 0 000000 000000
s 0000 0000 0 000000 000000
s 0000 0000 0 000000 000000
s 4000 0000 1 400000 000000
s 4000 0000 1 400000 000000
s 4000 0000 1 3ff000 000000
s 4000 0000 1 3fe000 000000
s 4000 0000 1 3fd004 000000
s 4000 0000 1 3fc00c 000000
s 4000 0000 0 3fc00c 000000
s 4000 0000 0 3fc00c 000000
t 5 iq_correction
w 03 80000000
w 04 80000000
w 01 00001000
w 02 0003f000
s 1000 0200 0 104000 01c000
s 7fff 8000 0 7fffff 800000
s 8000 7fff 0 800000 7fffff
s ffff 0001 0 fffefc 000104
t 6 back_to_back
w 01 00000000
w 02 00000000
s 0001 0010 0 000100 001000
s 0002 0020 0 000200 002000
s 0003 0030 0 000300 003000
s 0004 0040 0 000400 004000
s 0005 0050 0 000500 005000
s 0006 0060 0 000600 006000

// File: bench/rx_frontend_tb.sv
// Testbench for the receive front end
// Reads settings writes and samples from the case file, checks I and Q four cycles later

`timescale 1ns/10ps

module rx_frontend_tb;
   import rx_pkg::*;

   localparam int PIPE_DEPTH = 4;   // Drive edge to output edge

   logic        clk;
   logic        arst_n;
   logic        set_stb;
   set_addr_t   set_addr;
   set_data_t   set_data;
   adc_sample_t adc_a;
   adc_sample_t adc_b;
   logic        run;
   sample_t     i_out;
   sample_t     q_out;

   string   lines[$];
   logic    pend_valid[$];
   sample_t pend_i[$];
   sample_t pend_q[$];

   int      errors = 0;
   int      checks = 0;
   int      grp_errors = 0;
   int      grp_checks = 0;
   int      grp_num = 0;
   string   grp_name = "";
   bit      grp_open = 1'b0;
   bit      last_was_sample = 1'b0;
   int      cycles = 0;
   int      cycle_limit = 0;

   logic    chk_v;
   sample_t chk_i;
   sample_t chk_q;

   rx_clock_gen clk0 (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   rx_frontend #(.BASE(0)) dut0 (
      .clk        (clk),
      .arst_n_i   (arst_n),
      .set_stb_i  (set_stb),
      .set_addr_i (set_addr),
      .set_data_i (set_data),
      .adc_a_i    (adc_a),
      .adc_b_i    (adc_b),
      .run_i      (run),
      .i_o        (i_out),
      .q_o        (q_out)
   );

   // One clock of stimulus, with the expectation queued for later
   task automatic drive_cycle(input logic stb, input set_addr_t addr, input set_data_t data,
                              input adc_sample_t a, input adc_sample_t b, input logic r,
                              input logic chk, input sample_t exp_i, input sample_t exp_q);
      @(posedge clk);
      set_stb  <= stb;
      set_addr <= addr;
      set_data <= data;
      adc_a    <= a;
      adc_b    <= b;
      run      <= r;
      pend_valid.push_back(chk);
      pend_i.push_back(exp_i);
      pend_q.push_back(exp_q);
   endtask

   // Idle cycles until every pending sample has been compared
   task automatic flush_pipeline();
      repeat (PIPE_DEPTH) drive_cycle(1'b0, '0, '0, '0, '0, 1'b0, 1'b0, '0, '0);
      @(negedge clk);
      #1;
   endtask

   task automatic close_group();
      if (grp_open)
      begin
         flush_pipeline();
         $display("Test %0d %s: %0d checks, %0d errors, %s", grp_num, grp_name,
                  grp_checks, grp_errors, (grp_errors == 0) ? "pass" : "fail");
      end
      grp_open   = 1'b0;
      grp_checks = 0;
      grp_errors = 0;
   endtask

   task automatic read_cases(output bit ok);
      int    fd;
      int    n;
      string line;
      fd = $fopen("bench/rx_cases.txt", "r");
      ok = (fd != 0);
      if (ok)
      begin
         while (!$feof(fd))
         begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#" && line.getc(0) != "\n")
               lines.push_back(line);
         end
         $fclose(fd);
      end
   endtask

   task automatic run_line(input string line);
      byte         tag;
      string       rest;
      set_addr_t   addr;
      set_data_t   data;
      adc_sample_t a;
      adc_sample_t b;
      logic        r;
      sample_t     exp_i;
      sample_t     exp_q;
      tag  = line.getc(0);
      rest = line.substr(2, line.len() - 1);
      if (tag == "t")
      begin
         close_group();
         void'($sscanf(rest, "%d %s", grp_num, grp_name));
         grp_open        = 1'b1;
         last_was_sample = 1'b0;
      end
      else if (tag == "w")
      begin
         if (last_was_sample)
            flush_pipeline();   // Coefficients must not change under samples in flight
         void'($sscanf(rest, "%h %h", addr, data));
         drive_cycle(1'b1, addr, data, '0, '0, 1'b0, 1'b0, '0, '0);
         last_was_sample = 1'b0;
      end
      else if (tag == "s")
      begin
         void'($sscanf(rest, "%h %h %h %h %h", a, b, r, exp_i, exp_q));
         drive_cycle(1'b0, '0, '0, a, b, r, 1'b1, exp_i, exp_q);
         last_was_sample = 1'b1;
      end
      else
      begin
         $display("Unknown line in case file: %s", line);
         errors++;
      end
   endtask

   // Compare outputs away from the driving edge
   always @(negedge clk)
   begin
      if (pend_valid.size() > PIPE_DEPTH)
      begin
         chk_v = pend_valid.pop_front();
         chk_i = pend_i.pop_front();
         chk_q = pend_q.pop_front();
         if (chk_v)
         begin
            checks++;
            grp_checks++;
            assert (i_out === chk_i)
            else
            begin
               $display("Mismatch i_o: got %h, expected %h", i_out, chk_i);
               errors++;
               grp_errors++;
            end
            assert (q_out === chk_q)
            else
            begin
               $display("Mismatch q_o: got %h, expected %h", q_out, chk_q);
               errors++;
               grp_errors++;
            end
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial
   begin
      bit ok;
      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      adc_a    = '0;
      adc_b    = '0;
      run      = 1'b0;
      read_cases(ok);
      if (!ok)
      begin
         $display("Could not open the case file bench/rx_cases.txt");
         $display("ERRORS FOUND");
         $finish;
      end
      else
      begin
         cycle_limit = 2 * lines.size() + 200;
         wait (arst_n === 1'b1);
         foreach (lines[k])
            run_line(lines[k]);
         close_group();
         $display("Summary: %0d checks, %0d errors", checks, errors);
         if (errors == 0)
            $display("NO ERRORS");
         else
            $display("ERRORS FOUND");
         $finish;
      end
   end

endmodule

// File: bench/rx_clock_gen.sv
// Testbench clock and asynchronous reset generator

`timescale 1ns/10ps

module rx_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 16
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial
   begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      arst_n_o <= 1'b1;   // Release on an edge
   end

endmodule

// File: logic/rx_frontend.sv
// Receive front end top level
// Channel swap, settings registers, DC-offset removal and optional IQ correction

`timescale 1ns/10ps

`include "rx_macros.svh"

module rx_frontend #(
   parameter int BASE      = 0,
   parameter int IQCOMP_EN = `RX_IQCOMP_EN
) (
   input  logic                clk,
   input  logic                arst_n_i,
   input  logic                set_stb_i,
   input  rx_pkg::set_addr_t   set_addr_i,
   input  rx_pkg::set_data_t   set_data_i,
   input  rx_pkg::adc_sample_t adc_a_i,
   input  rx_pkg::adc_sample_t adc_b_i,
   input  logic                run_i,
   output rx_pkg::sample_t     i_o,
   output rx_pkg::sample_t     q_o
);
   import rx_pkg::*;

   adc_sample_t adc_i;
   adc_sample_t adc_q;
   sample_t     i_wide;
   sample_t     q_wide;
   sample_t     i_ofs;
   sample_t     q_ofs;

   rx_cfg_if cfg ();

   rx_settings_regs #(.BASE(BASE)) regs0 (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .cfg_o      (cfg.regs)
   );

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         adc_i <= '0;
         adc_q <= '0;
      end
      else if (cfg.swap_iq)
      begin
         adc_i <= adc_b_i;   // I from b, Q from a
         adc_q <= adc_a_i;
      end
      else
      begin
         adc_i <= adc_a_i;
         adc_q <= adc_b_i;
      end
   end

   // Left-justify into the wider datapath
   assign i_wide = {adc_i, {(`RX_SAMPLE_W-`RX_ADC_W){1'b0}}};
   assign q_wide = {adc_q, {(`RX_SAMPLE_W-`RX_ADC_W){1'b0}}};

   rx_dc_offset dc_i (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .in_i     (i_wide),
      .run_i    (run_i),
      .load_i   (cfg.dc_load_i),
      .fixed_i  (cfg.dc_fixed),
      .value_i  (cfg.dc_value),
      .out_o    (i_ofs)
   );

   rx_dc_offset dc_q (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .in_i     (q_wide),
      .run_i    (run_i),
      .load_i   (cfg.dc_load_q),
      .fixed_i  (cfg.dc_fixed),
      .value_i  (cfg.dc_value),
      .out_o    (q_ofs)
   );

   generate
      if (IQCOMP_EN == 1)
      begin : g_iqc
         rx_iq_correct iqc0 (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .i_i      (i_ofs),
            .q_i      (q_ofs),
            .cfg_i    (cfg.iqc),
            .i_o      (i_o),
            .q_o      (q_o)
         );
      end
      else
      begin : g_bypass
         assign i_o = i_ofs;   // Two-cycle path
         assign q_o = q_ofs;
      end
   endgenerate

endmodule

// File: logic/rx_iq_correct.sv
// IQ imbalance correction
// Magnitude and phase products from I, delay alignment, saturating adders

`timescale 1ns/10ps

`include "rx_macros.svh"

module rx_iq_correct (
   input  logic            clk,
   input  logic            arst_n_i,
   input  rx_pkg::sample_t i_i,
   input  rx_pkg::sample_t q_i,
   rx_cfg_if.iqc           cfg_i,
   output rx_pkg::sample_t i_o,
   output rx_pkg::sample_t q_o
);
   import rx_pkg::*;

   localparam int PROD_W = 2 * `RX_COEF_W;

   coef_t                        i_corr;
   logic signed [PROD_W-1:0]     prod_mag;
   logic signed [PROD_W-1:0]     prod_phase;
   sample_t                      i_dly;
   sample_t                      q_dly;
   sample_t                      corr_i;
   sample_t                      corr_q;
   logic signed [`RX_SAMPLE_W:0] sum_i;
   logic signed [`RX_SAMPLE_W:0] sum_q;

   // Multiplier input is the top of I
   assign i_corr = i_i[`RX_SAMPLE_W-1 -: `RX_COEF_W];

   // Stage 1, multiply and delay the samples to match
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         prod_mag   <= '0;
         prod_phase <= '0;
         i_dly      <= '0;
         q_dly      <= '0;
      end
      else
      begin
         prod_mag   <= i_corr * cfg_i.mag_corr;
         prod_phase <= i_corr * cfg_i.phase_corr;
         i_dly      <= i_i;
         q_dly      <= q_i;
      end
   end

   // Bits 35 down to 12 of each product
   assign corr_i = prod_mag[PROD_W-1 -: `RX_SAMPLE_W];
   assign corr_q = prod_phase[PROD_W-1 -: `RX_SAMPLE_W];

   assign sum_i = i_dly + corr_i;
   assign sum_q = q_dly + corr_q;

   // Stage 2, add and clip
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         i_o <= '0;
         q_o <= '0;
      end
      else
      begin
         i_o <= sat_sample(sum_i);
         q_o <= sat_sample(sum_q);
      end
   end

endmodule

// File: logic/rx_dc_offset.sv
// One channel of DC-offset removal
// Fixed offset or first-order tracking loop, saturated registered output

`timescale 1ns/10ps

`include "rx_macros.svh"

module rx_dc_offset (
   input  logic            clk,
   input  logic            arst_n_i,
   input  rx_pkg::sample_t in_i,
   input  logic            run_i,
   input  logic            load_i,
   input  logic            fixed_i,
   input  rx_pkg::sample_t value_i,
   output rx_pkg::sample_t out_o
);
   import rx_pkg::*;

   localparam int ACC_W = `RX_SAMPLE_W + `RX_DC_SHIFT;

   logic signed [ACC_W-1:0]       acc;
   logic                          fixed;
   sample_t                       offset;
   logic signed [`RX_SAMPLE_W:0]  diff;

   // Top bits of the accumulator, i.e. acc >>> RX_DC_SHIFT
   assign offset = acc[ACC_W-1 -: `RX_SAMPLE_W];

   // One extra bit so the difference cannot wrap
   assign diff = in_i - offset;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         out_o <= '0;
      end
      else
      begin
         out_o <= sat_sample(diff);
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         acc   <= '0;
         fixed <= 1'b0;
      end
      else if (load_i)
      begin
         acc   <= {value_i, {`RX_DC_SHIFT{1'b0}}};
         fixed <= fixed_i;
      end
      else if (run_i && !fixed)
      begin
         // Integrate the residual so the offset follows the input mean
         acc <= acc + ACC_W'(out_o);
      end
   end

endmodule

// File: logic/rx_settings_regs.sv
// Settings-bus decoder and configuration registers
// DC writes are turned into load pulses for the two offset channels

`timescale 1ns/10ps

`include "rx_macros.svh"

module rx_settings_regs #(
   parameter int BASE = 0
) (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic              set_stb_i,
   input  rx_pkg::set_addr_t set_addr_i,
   input  rx_pkg::set_data_t set_data_i,
   rx_cfg_if.regs            cfg_o
);
   import rx_pkg::*;

   localparam set_addr_t ADDR_SWAP  = set_addr_t'(BASE + `RX_ADDR_SWAP);
   localparam set_addr_t ADDR_MAG   = set_addr_t'(BASE + `RX_ADDR_MAG);
   localparam set_addr_t ADDR_PHASE = set_addr_t'(BASE + `RX_ADDR_PHASE);
   localparam set_addr_t ADDR_DC_I  = set_addr_t'(BASE + `RX_ADDR_DC_I);
   localparam set_addr_t ADDR_DC_Q  = set_addr_t'(BASE + `RX_ADDR_DC_Q);

   logic wr_swap;
   logic wr_mag;
   logic wr_phase;
   logic wr_dc_i;
   logic wr_dc_q;

   assign wr_swap  = set_stb_i && (set_addr_i == ADDR_SWAP);
   assign wr_mag   = set_stb_i && (set_addr_i == ADDR_MAG);
   assign wr_phase = set_stb_i && (set_addr_i == ADDR_PHASE);
   assign wr_dc_i  = set_stb_i && (set_addr_i == ADDR_DC_I);
   assign wr_dc_q  = set_stb_i && (set_addr_i == ADDR_DC_Q);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cfg_o.swap_iq    <= 1'b0;
         cfg_o.mag_corr   <= '0;
         cfg_o.phase_corr <= '0;
         cfg_o.dc_value   <= '0;
         cfg_o.dc_fixed   <= 1'b0;   // Tracking mode
         cfg_o.dc_load_i  <= 1'b0;
         cfg_o.dc_load_q  <= 1'b0;
      end
      else
      begin
         if (wr_swap)
            cfg_o.swap_iq <= set_data_i[0];
         if (wr_mag)
            cfg_o.mag_corr <= coef_t'(set_data_i[`RX_COEF_W-1:0]);
         if (wr_phase)
            cfg_o.phase_corr <= coef_t'(set_data_i[`RX_COEF_W-1:0]);

         // Bit 31 selects the mode, the 24 bits below it are the offset
         if (wr_dc_i || wr_dc_q)
         begin
            cfg_o.dc_value <= set_data_i[`RX_DATA_W-2 -: `RX_SAMPLE_W];
            cfg_o.dc_fixed <= set_data_i[`RX_DATA_W-1];
         end
         cfg_o.dc_load_i <= wr_dc_i;   // Channel loads on the next edge
         cfg_o.dc_load_q <= wr_dc_q;
      end
   end

endmodule

// File: logic/rx_cfg_if.sv
// Programmed configuration from the register block to the datapath

`timescale 1ns/10ps

`include "rx_macros.svh"

interface rx_cfg_if;
   import rx_pkg::*;

   logic    swap_iq;
   coef_t   mag_corr;
   coef_t   phase_corr;
   sample_t dc_value;      // Shared by both DC channels
   logic    dc_fixed;
   logic    dc_load_i;     // One-cycle pulse
   logic    dc_load_q;     // One-cycle pulse

   modport regs (
      output swap_iq,
      output mag_corr,
      output phase_corr,
      output dc_value,
      output dc_fixed,
      output dc_load_i,
      output dc_load_q
   );

   modport iqc (
      input mag_corr,
      input phase_corr
   );

endinterface

// File: logic/rx_pkg.sv
// Sample, coefficient and settings-bus types
// Saturation of a one-bit-wider sum back to a front-end sample

`include "rx_macros.svh"

package rx_pkg;

   typedef logic signed [`RX_ADC_W-1:0]    adc_sample_t;
   typedef logic signed [`RX_SAMPLE_W-1:0] sample_t;
   typedef logic signed [`RX_COEF_W-1:0]   coef_t;
   typedef logic [`RX_ADDR_W-1:0]          set_addr_t;
   typedef logic [`RX_DATA_W-1:0]          set_data_t;

   // Clip to the most positive or most negative sample on overflow
   function automatic sample_t sat_sample(input logic signed [`RX_SAMPLE_W:0] x);
      if (x[`RX_SAMPLE_W] != x[`RX_SAMPLE_W-1])
      begin
         return x[`RX_SAMPLE_W] ? {1'b1, {(`RX_SAMPLE_W-1){1'b0}}}
                                : {1'b0, {(`RX_SAMPLE_W-1){1'b1}}};
      end
      return x[`RX_SAMPLE_W-1:0];
   endfunction

endpackage

// File: logic/rx_macros.svh
// Widths, settings-bus register map and defaults for the receive front end

`ifndef RX_MACROS_SVH
`define RX_MACROS_SVH

// Sample and coefficient widths
`define RX_ADC_W     16
`define RX_SAMPLE_W  24
`define RX_COEF_W    18

// Settings bus
`define RX_ADDR_W    8
`define RX_DATA_W    32

// Register offsets from BASE
`define RX_ADDR_SWAP   0
`define RX_ADDR_MAG    1
`define RX_ADDR_PHASE  2
`define RX_ADDR_DC_I   3
`define RX_ADDR_DC_Q   4

`define RX_DC_SHIFT   10   // Loop gain of 2^-10
`define RX_IQCOMP_EN  1

`endif
